/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and register file sizes.
`define CORE_XLEN    32
`define CORE_NREG    32
`define CORE_RIDX_W  5

// instruction field positions in the fixed 32-bit format.
`define OPC_MSB      31
`define OPC_LSB      26
`define RD_LSB       21
`define RJ_LSB       16
`define RK_LSB       11

// immediate sits in the low bits and overlaps rk.
`define IMM_W        16

`endif

/* rtl/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [2*`CORE_XLEN-1:0] prod_t;
    typedef logic [`CORE_XLEN/8-1:0] byte_en_t;
    typedef logic [`CORE_RIDX_W-1:0] reg_idx_t;

    typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
        OP_ADD  = 6'h00,
        OP_SUB  = 6'h01,
        OP_AND  = 6'h02,
        OP_OR   = 6'h03,
        OP_SLT  = 6'h04,
        OP_ADDI = 6'h05,
        OP_LUI  = 6'h06,
        OP_MUL  = 6'h07,
        OP_MULH = 6'h08,
        OP_LD_W = 6'h09,
        OP_ST_W = 6'h0a
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        word_t    pc;
        alu_op_t  alu_op;
        word_t    src1;
        word_t    src2;
        word_t    st_value;
        logic     res_from_mem;
        logic     res_from_mul;
        logic     mul_high;
        logic     mem_we;
        logic     gr_we;
        reg_idx_t dest;
    } ds_to_es_t;

    typedef struct packed {
        logic     res_from_mul;
        logic     mul_high;
        logic     res_from_mem;
        logic     gr_we;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    pc;
    } es_to_ms_t;

    typedef struct packed {
        logic     gr_we;
        reg_idx_t dest;
        word_t    result;
        word_t    pc;
    } ms_to_ws_t;

    // block marks a result that is not ready yet.
    typedef struct packed {
        logic     we;
        logic     block;
        reg_idx_t dest;
        word_t    value;
    } fwd_t;

    typedef struct packed {
        logic     we;
        reg_idx_t waddr;
        word_t    wdata;
    } rf_wr_t;

    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } retire_t;

endpackage

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2,
    input  core_pkg::rf_wr_t   wr
);
    import core_pkg::*;

    word_t regs [`CORE_NREG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != '0) begin // r0 is hardwired.
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  core_pkg::word_t     inst,
    input  core_pkg::word_t     inst_pc,
    output logic                ds_allowin,
    input  logic                es_allowin,
    output logic                ds_to_es_valid,
    output core_pkg::ds_to_es_t ds_to_es_bus,
    input  core_pkg::fwd_t      es_fwd,
    input  core_pkg::fwd_t      ms_fwd,
    input  core_pkg::fwd_t      ws_fwd,
    input  core_pkg::rf_wr_t    rf_wr
);
    import core_pkg::*;

    logic     ds_valid;
    logic     ds_ready_go;
    logic     blocked;
    word_t    inst_r;
    word_t    ds_pc;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    reg_idx_t raddr2;
    word_t    imm_sext;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    val1;
    word_t    val2;
    alu_op_t  alu_op;
    logic     rtype;
    logic     uses_rj;
    logic     uses_r2;
    logic     gr_we_raw;
    logic     res_from_mem;
    logic     res_from_mul;
    logic     mul_high;
    logic     mem_we;

    function automatic logic fwd_hit(fwd_t f, reg_idx_t r);
        return f.we && f.dest == r;
    endfunction

    // youngest producer wins.
    function automatic word_t fwd_sel(reg_idx_t r, word_t rf_val, fwd_t e, fwd_t m, fwd_t w);
        if (fwd_hit(e, r)) return e.value;
        if (fwd_hit(m, r)) return m.value;
        if (fwd_hit(w, r)) return w.value;
        return rf_val;
    endfunction

    assign ds_ready_go    = !blocked;
    assign ds_allowin     = !ds_valid || ds_ready_go && es_allowin;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && ds_allowin) begin
            inst_r <= inst;
            ds_pc  <= inst_pc;
        end
    end

    assign opcode   = opcode_t'(inst_r[`OPC_MSB:`OPC_LSB]);
    assign rd       = inst_r[`RD_LSB +: `CORE_RIDX_W];
    assign rj       = inst_r[`RJ_LSB +: `CORE_RIDX_W];
    assign rk       = inst_r[`RK_LSB +: `CORE_RIDX_W];
    assign imm_sext = {{(`CORE_XLEN-`IMM_W){inst_r[`IMM_W-1]}}, inst_r[`IMM_W-1:0]};
    assign rtype    = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_MUL, OP_MULH};

    always_comb begin
        alu_op       = ALU_ADD;
        uses_rj      = 1'b1;
        gr_we_raw    = 1'b1;
        res_from_mem = 1'b0;
        res_from_mul = 1'b0;
        mul_high     = 1'b0;
        mem_we       = 1'b0;
        case (opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_SLT:  alu_op = ALU_SLT;
            OP_ADDI: alu_op = ALU_ADD;
            OP_LUI: begin
                alu_op  = ALU_LUI;
                uses_rj = 1'b0;
            end
            OP_MUL:  res_from_mul = 1'b1;
            OP_MULH: begin
                res_from_mul = 1'b1;
                mul_high     = 1'b1;
            end
            OP_LD_W: res_from_mem = 1'b1;
            OP_ST_W: begin
                mem_we    = 1'b1;
                gr_we_raw = 1'b0;
            end
            default: gr_we_raw = 1'b0; // unknown opcode retires as a no-op.
        endcase
    end

    assign uses_r2 = rtype || mem_we;
    assign raddr2  = mem_we ? rd : rk; // store data comes from rd.

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_wr)
    );

    assign val1 = fwd_sel(rj, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign val2 = fwd_sel(raddr2, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    // load or mul still in execute.
    assign blocked = es_fwd.block &&
                     ((uses_rj && fwd_hit(es_fwd, rj)) || (uses_r2 && fwd_hit(es_fwd, raddr2)));

    assign ds_to_es_bus = '{
        pc:           ds_pc,
        alu_op:       alu_op,
        src1:         val1,
        src2:         rtype ? val2 : imm_sext,
        st_value:     val2,
        res_from_mem: res_from_mem,
        res_from_mul: res_from_mul,
        mul_high:     mul_high,
        mem_we:       mem_we,
        gr_we:        gr_we_raw && (rd != '0),
        dest:         rd
    };

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ds_to_es_valid,
    input  core_pkg::ds_to_es_t ds_to_es_bus,
    output logic                es_allowin,
    input  logic                ms_allowin,
    output logic                es_to_ms_valid,
    output core_pkg::es_to_ms_t es_to_ms_bus,
    output core_pkg::fwd_t      es_fwd,
    output logic                data_sram_en,
    output core_pkg::byte_en_t  data_sram_we,
    output core_pkg::word_t     data_sram_addr,
    output core_pkg::word_t     data_sram_wdata,
    output core_pkg::word_t     mul_a,
    output core_pkg::word_t     mul_b,
    output logic                mul_go
);
    import core_pkg::*;

    logic      es_valid;
    logic      es_go;
    ds_to_es_t es_r;
    word_t     alu_result;

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_go          = es_to_ms_valid && ms_allowin; // transfer to memory stage.

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_r <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (es_r.alu_op)
            ALU_SUB: alu_result = es_r.src1 - es_r.src2;
            ALU_AND: alu_result = es_r.src1 & es_r.src2;
            ALU_OR:  alu_result = es_r.src1 | es_r.src2;
            ALU_SLT: alu_result = {{(`CORE_XLEN-1){1'b0}},
                                   ($signed(es_r.src1) < $signed(es_r.src2))};
            ALU_LUI: alu_result = {es_r.src2[`IMM_W-1:0], {(`CORE_XLEN-`IMM_W){1'b0}}};
            default: alu_result = es_r.src1 + es_r.src2; // also the load/store address.
        endcase
    end

    // access only on the transfer edge, so a stalled memory stage keeps its read data.
    assign data_sram_en    = es_go && (es_r.res_from_mem || es_r.mem_we);
    assign data_sram_we    = {($bits(byte_en_t)){es_go && es_r.mem_we}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_r.st_value;

    assign mul_a  = es_r.src1;
    assign mul_b  = es_r.src2;
    assign mul_go = es_go && es_r.res_from_mul;

    assign es_to_ms_bus = '{
        res_from_mul: es_r.res_from_mul,
        mul_high:     es_r.mul_high,
        res_from_mem: es_r.res_from_mem,
        gr_we:        es_r.gr_we,
        dest:         es_r.dest,
        alu_result:   alu_result,
        pc:           es_r.pc
    };

    assign es_fwd = '{
        we:    es_valid && es_r.gr_we,
        block: es_r.res_from_mem || es_r.res_from_mul,
        dest:  es_r.dest,
        value: alu_result
    };

endmodule

/* rtl/multiplier.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module multiplier (
    input  logic            clk,
    input  logic            mul_go,
    input  core_pkg::word_t mul_a,
    input  core_pkg::word_t mul_b,
    output core_pkg::prod_t mul_product
);

    logic signed [2*`CORE_XLEN-1:0] product; // full signed product.

    assign product = $signed(mul_a) * $signed(mul_b);

    // loads with the execute-to-memory transfer and holds while the memory stage stalls.
    always_ff @(posedge clk) begin
        if (mul_go) begin
            mul_product <= product;
        end
    end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module mem_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                es_to_ms_valid,
    input  core_pkg::es_to_ms_t es_to_ms_bus,
    output logic                ms_allowin,
    input  logic                ws_allowin,
    output logic                ms_to_ws_valid,
    output core_pkg::ms_to_ws_t ms_to_ws_bus,
    input  core_pkg::word_t     data_sram_rdata,
    input  core_pkg::prod_t     mul_product,
    output core_pkg::fwd_t      ms_fwd
);
    import core_pkg::*;

    logic      ms_valid;
    es_to_ms_t ms_r;
    word_t     mul_result;
    word_t     final_result;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_r <= es_to_ms_bus;
        end
    end

    assign mul_result = ms_r.mul_high ? mul_product[2*`CORE_XLEN-1:`CORE_XLEN] :
                                        mul_product[`CORE_XLEN-1:0];

    assign final_result = ms_r.res_from_mul ? mul_result      :
                          ms_r.res_from_mem ? data_sram_rdata :
                                              ms_r.alu_result;

    assign ms_to_ws_bus = '{
        gr_we:  ms_r.gr_we,
        dest:   ms_r.dest,
        result: final_result,
        pc:     ms_r.pc
    };

    // final value is known here so it never blocks.
    assign ms_fwd = '{
        we:    ms_valid && ms_r.gr_we,
        block: 1'b0,
        dest:  ms_r.dest,
        value: final_result
    };

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ms_to_ws_valid,
    input  core_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic                ws_allowin,
    input  logic                retire_ready,
    output logic                retire_valid,
    output core_pkg::retire_t   retire,
    output core_pkg::rf_wr_t    rf_wr,
    output core_pkg::fwd_t      ws_fwd
);
    import core_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_r;

    assign ws_allowin   = !ws_valid || retire_ready;
    assign retire_valid = ws_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_r <= ms_to_ws_bus;
        end
    end

    assign retire = '{pc: ws_r.pc, we: ws_r.gr_we, dest: ws_r.dest, data: ws_r.result};

    // register write happens once, on the retire handshake.
    assign rf_wr = '{
        we:    ws_valid && retire_ready && ws_r.gr_we,
        waddr: ws_r.dest,
        wdata: ws_r.result
    };

    assign ws_fwd = '{we: ws_valid && ws_r.gr_we, block: 1'b0, dest: ws_r.dest, value: ws_r.result};

endmodule

/* rtl/mini_core.sv */
`timescale 1ns/1ps

module mini_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  core_pkg::word_t    inst,
    input  core_pkg::word_t    inst_pc,
    output logic               inst_allowin,
    output logic               retire_valid,
    output core_pkg::retire_t  retire,
    input  logic               retire_ready,
    output logic               data_sram_en,
    output core_pkg::byte_en_t data_sram_we,
    output core_pkg::word_t    data_sram_addr,
    output core_pkg::word_t    data_sram_wdata,
    input  core_pkg::word_t    data_sram_rdata
);
    import core_pkg::*;

    logic      es_allowin;
    logic      ms_allowin;
    logic      ws_allowin;
    logic      ds_to_es_valid;
    logic      es_to_ms_valid;
    logic      ms_to_ws_valid;
    ds_to_es_t ds_to_es_bus;
    es_to_ms_t es_to_ms_bus;
    ms_to_ws_t ms_to_ws_bus;
    fwd_t      es_fwd;
    fwd_t      ms_fwd;
    fwd_t      ws_fwd;
    rf_wr_t    rf_wr;
    word_t     mul_a;
    word_t     mul_b;
    logic      mul_go;
    prod_t     mul_product;

    decode_stage u_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .ds_allowin     (inst_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rf_wr          (rf_wr)
    );

    execute_stage u_execute_stage (
        .clk             (clk),
        .reset           (reset),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es_bus    (ds_to_es_bus),
        .es_allowin      (es_allowin),
        .ms_allowin      (ms_allowin),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .es_fwd          (es_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .mul_a           (mul_a),
        .mul_b           (mul_b),
        .mul_go          (mul_go)
    );

    multiplier u_multiplier (
        .clk         (clk),
        .mul_go      (mul_go),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_product (mul_product)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .reset           (reset),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .ms_allowin      (ms_allowin),
        .ws_allowin      (ws_allowin),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .data_sram_rdata (data_sram_rdata),
        .mul_product     (mul_product),
        .ms_fwd          (ms_fwd)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .rf_wr          (rf_wr),
        .ws_fwd         (ws_fwd)
    );

endmodule

/* tb/core_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;
    import core_pkg::*;

    localparam int NUM_INSTS = 300;
    localparam int WINDOW    = 64;

    logic     clk;
    logic     reset;
    logic     inst_valid;
    word_t    inst;
    word_t    inst_pc;
    logic     inst_allowin;
    logic     retire_valid;
    retire_t  retire;
    logic     retire_ready = 1'b1;
    logic     data_sram_en;
    byte_en_t data_sram_we;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata = '0;

    word_t    prog [NUM_INSTS];
    word_t    sram [WINDOW];
    word_t    model_mem [WINDOW];
    word_t    model_reg [`CORE_NREG];
    word_t    wr_addr_q [$];
    word_t    wr_data_q [$];
    int       retired = 0;
    logic     hold_valid = 1'b0;
    retire_t  held;

    mini_core dut0 (
        .clk             (clk),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_allowin    (inst_allowin),
        .retire_valid    (retire_valid),
        .retire          (retire),
        .retire_ready    (retire_ready),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    function automatic word_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rj, logic [15:0] imm);
        return {op, rd, rj, imm};
    endfunction

    function automatic word_t fill_word(int i);
        return 32'h1357_9bdf ^ (word_t'(i) * 32'h0001_0203);
    endfunction

    // first eight are adds, so they read the cleared register file.
    task automatic build_program();
        int       kind;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic [15:0] imm;
        for (int i = 0; i < NUM_INSTS; i++) begin
            rd   = reg_idx_t'($urandom_range(7));
            rj   = reg_idx_t'($urandom_range(7));
            rk   = reg_idx_t'($urandom_range(7));
            imm  = 16'($urandom);
            kind = (i < 8) ? -1 : int'($urandom_range(99));
            if (kind < 0)       prog[i] = encode(OP_ADD, rd, rj, {rk, 11'h0});
            else if (kind < 30) prog[i] = encode(opcode_t'(6'($urandom_range(4))), rd, rj,
                                                 {rk, 11'h0});
            else if (kind < 42) prog[i] = encode(OP_ADDI, rd, rj, imm);
            else if (kind < 52) prog[i] = encode(OP_LUI, rd, rj, imm);
            else if (kind < 60) prog[i] = encode(OP_MUL, rd, rj, {rk, 11'h0});
            else if (kind < 68) prog[i] = encode(OP_MULH, rd, rj, {rk, 11'h0});
            else if (kind < 84) prog[i] = encode(OP_LD_W, rd, rj, imm);
            else                prog[i] = encode(OP_ST_W, rd, rj, imm);
        end
    endtask

    // reference model that runs one instruction as it retires.
    task automatic check_retire(input retire_t r);
        word_t    ins;
        opcode_t  op;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm_s;
        word_t    addr;
        word_t    res;
        logic     exp_we;
        logic signed [63:0] prod;
        ins    = prog[retired];
        op     = opcode_t'(ins[31:26]);
        rd     = ins[25:21];
        a      = model_reg[ins[20:16]];
        b      = model_reg[ins[15:11]];
        imm_s  = {{16{ins[15]}}, ins[15:0]};
        addr   = a + imm_s;
        prod   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        exp_we = (op != OP_ST_W) && (rd != '0);
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = addr;
            OP_LUI:  res = {ins[15:0], 16'h0000};
            OP_MUL:  res = prod[31:0];
            OP_MULH: res = prod[63:32];
            OP_LD_W: res = model_mem[addr[7:2]];
            default: res = addr;
        endcase
        assert (r.pc == word_t'(retired * 4))
            else report_mismatch($sformatf("retired pc %h, expected %h", r.pc, retired * 4));
        assert (r.we == exp_we)
            else report_mismatch($sformatf("pc %h: write enable %b, expected %b",
                                           r.pc, r.we, exp_we));
        if (exp_we) begin
            assert (r.dest == rd && r.data == res)
                else report_mismatch($sformatf("pc %h: r%0d = %h, expected r%0d = %h",
                                               r.pc, r.dest, r.data, rd, res));
            model_reg[rd] = res;
        end
        if (op == OP_ST_W) begin
            if (wr_addr_q.size() == 0) begin
                abort_run($sformatf("store at pc %h retired without an SRAM write", r.pc));
            end else begin
                assert (wr_addr_q[0] == addr && wr_data_q[0] == model_reg[rd])
                    else report_mismatch($sformatf(
                        "store at pc %h wrote %h to %h, expected %h to %h",
                        r.pc, wr_data_q[0], wr_addr_q[0], model_reg[rd], addr));
                model_mem[addr[7:2]] = model_reg[rd];
                void'(wr_addr_q.pop_front());
                void'(wr_data_q.pop_front());
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // data SRAM model whose read data follows the enable by one cycle and holds.
    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_we != '0) begin
                sram[data_sram_addr[7:2]] <= data_sram_wdata;
                wr_addr_q.push_back(data_sram_addr);
                wr_data_q.push_back(data_sram_wdata);
            end else begin
                data_sram_rdata <= sram[data_sram_addr[7:2]];
            end
        end
    end

    always @(posedge clk) begin
        retire_ready <= reset ? 1'b1 : ($urandom_range(99) >= 40);
    end

    always @(posedge clk) begin
        if (reset) begin
            hold_valid = 1'b0;
        end else begin
            if (hold_valid) begin
                assert (retire_valid && retire == held)
                    else report_mismatch("retire record changed before it was accepted");
            end
            if (retire_valid && retire_ready) begin
                if (retired >= NUM_INSTS) begin
                    abort_run("an instruction retired after the end of the program");
                end else begin
                    check_retire(retire);
                    retired++;
                end
            end
            hold_valid = retire_valid && !retire_ready;
            held       = retire;
        end
    end

    initial begin
        repeat (NUM_INSTS * 20) @(posedge clk);
        abort_run("timeout: the program did not finish retiring");
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        void'($urandom(29));
        build_program();
        for (int i = 0; i < WINDOW; i++) begin
            sram[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < `CORE_NREG; i++) begin
            model_reg[i] = '0;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!retire_valid && !data_sram_en && inst_allowin)
            else report_mismatch("pipeline not idle after reset");

        for (int i = 0; i < NUM_INSTS; i++) begin
            if ($urandom_range(9) == 0) begin // occasional bubble.
                inst_valid <= 1'b0;
                @(posedge clk);
            end
            inst_valid <= 1'b1;
            inst       <= prog[i];
            inst_pc    <= word_t'(i * 4);
            @(posedge clk);
            while (!inst_allowin) @(posedge clk);
        end
        inst_valid <= 1'b0;

        wait (retired == NUM_INSTS);
        repeat (4) @(posedge clk);
        if (wr_addr_q.size() != 0) begin
            abort_run("the SRAM saw a write that no retired store accounts for");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* list.f */
+incdir+include
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/multiplier.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mini_core.sv
tb/core_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build core_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module core_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcore_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
